/* hdl/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////////////
// Bus widths.

// Program counter and ROM address.
`define CPU_PC_W 13

// One instruction word.
`define CPU_INSTR_W 12

// Accumulators and RAM data.
`define CPU_DATA_W 4

// RAM address and the X and Y index registers.
`define CPU_MADDR_W 12

// Immediate field of the long forms.
`define CPU_IMM_W 8

//////////////////////////////
// Instruction sequencing.

`define CPU_STEPS 4 // Cycles per instruction.
`define CPU_STEP_W 2 // Holds 0 to CPU_STEPS-1.

// Write-back cycle.
`define CPU_LAST_STEP (`CPU_STEP_W'(`CPU_STEPS - 1))

`endif

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Top four bits of the instruction word.
  typedef enum logic [3:0] {
    op_ld_ri, // r <= imm4.
    op_add_ri, // r <= r + imm4.
    op_add_rq,
    op_sub_rq,
    op_and_rq,
    op_or_rq,
    op_xor_rq,
    op_ld_x, // X <= imm8.
    op_ld_y, // Y <= imm8.
    op_inc_x,
    op_jp,
    op_jp_c,
    op_jp_nc,
    op_jp_z,
    op_jp_nz,
    op_halt
  } opcode_e;

  // Two-bit register operand code.
  typedef enum logic [1:0] {
    sel_a,
    sel_b,
    sel_mx, // RAM at X.
    sel_my // RAM at Y.
  } reg_sel_e;

  typedef enum logic [2:0] {
    alu_pass, // Left operand through.
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  // Opcodes whose result lands in operand r.
  function automatic logic writes_r(opcode_e op);
    return op inside {op_ld_ri, op_add_ri, op_add_rq, op_sub_rq,
                      op_and_rq, op_or_rq, op_xor_rq};
  endfunction

endpackage

`default_nettype wire

/* hdl/fetch_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_decode import cpu_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`CPU_INSTR_W-1:0]  rom_data,
  input  wire logic                     carry,
  input  wire logic                     zero,
  output logic      [`CPU_PC_W-1:0]     rom_addr,
  output logic      [`CPU_STEP_W-1:0]   step,
  output opcode_e                       opcode,
  output reg_sel_e                      r_sel,
  output reg_sel_e                      q_sel,
  output alu_op_e                       alu_op,
  output logic      [`CPU_IMM_W-1:0]    imm,
  output logic                          halt
);

  logic [`CPU_PC_W-1:0]    pc;
  logic [`CPU_INSTR_W-1:0] ir;
  logic [`CPU_INSTR_W-1:0] instr;
  logic                    last_step;
  logic                    jump_taken;

  assign last_step = (step == `CPU_LAST_STEP);
  assign rom_addr  = pc;

  // ROM word is on the pins during step 1, latched afterwards.
  assign instr = (step == `CPU_STEP_W'(1)) ? rom_data : ir;

  //////////////////////////////
  // Decode.

  always_comb begin
    opcode = opcode_e'(instr[`CPU_INSTR_W-1 -: 4]);
    imm    = instr[`CPU_IMM_W-1:0];
    r_sel  = reg_sel_e'(instr[3:2]);
    q_sel  = reg_sel_e'(instr[1:0]);
    alu_op = alu_pass;
    case (opcode)
      op_ld_ri, op_add_ri: begin
        // Short forms read r on the right side.
        r_sel  = reg_sel_e'(instr[5:4]);
        q_sel  = reg_sel_e'(instr[5:4]);
        alu_op = (opcode == op_add_ri) ? alu_add : alu_pass;
      end
      op_add_rq: alu_op = alu_add;
      op_sub_rq: alu_op = alu_sub;
      op_and_rq: alu_op = alu_and;
      op_or_rq:  alu_op = alu_or;
      op_xor_rq: alu_op = alu_xor;
      default:   alu_op = alu_pass;
    endcase
  end

  always_comb begin
    case (opcode)
      op_jp:    jump_taken = 1'b1;
      op_jp_c:  jump_taken = carry;
      op_jp_nc: jump_taken = !carry;
      op_jp_z:  jump_taken = zero;
      op_jp_nz: jump_taken = !zero;
      default:  jump_taken = 1'b0;
    endcase
  end

  // Halt holds step at 3, so this stays high.
  assign halt = last_step && (opcode == op_halt);

  //////////////////////////////
  // Sequencer and program counter.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc   <= '0;
      step <= '0;
      ir   <= '0;
    end else if (!halt) begin
      step <= last_step ? '0 : step + `CPU_STEP_W'(1);
      if (step == `CPU_STEP_W'(1)) begin
        ir <= rom_data;
      end
      if (last_step) begin
        if (jump_taken) begin
          pc <= {pc[`CPU_PC_W-1:`CPU_IMM_W], imm}; // Page kept.
        end else begin
          pc <= pc + `CPU_PC_W'(1);
        end
      end
    end
  end

  a_halt_freezes: assert property (
    @(posedge clk) disable iff (!rst_n)
    halt |=> halt
  ) else $error("halt dropped while the core was frozen");

endmodule

`default_nettype wire

/* hdl/alu.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
  input  wire alu_op_e                  alu_op,
  input  wire logic [`CPU_DATA_W-1:0]   lhs,
  input  wire logic [`CPU_DATA_W-1:0]   rhs,
  output logic                          carry_out,
  output logic                          zero_out,
  output logic      [`CPU_DATA_W-1:0]   result
);

  // One extra bit on top catches carry and borrow.
  logic [`CPU_DATA_W:0] wide;
  logic [`CPU_DATA_W:0] lhs_ext;
  logic [`CPU_DATA_W:0] rhs_ext;

  assign lhs_ext = {1'b0, lhs};
  assign rhs_ext = {1'b0, rhs};

  always_comb begin
    case (alu_op)
      alu_pass: begin
        wide = lhs_ext;
      end
      alu_add: begin
        wide = lhs_ext + rhs_ext; // Carry out of bit 3.
      end
      alu_sub: begin
        // Wraps into the top bit when rhs is larger.
        wide = lhs_ext - rhs_ext;
      end
      alu_and: begin
        wide = lhs_ext & rhs_ext;
      end
      alu_or: begin
        wide = lhs_ext | rhs_ext;
      end
      alu_xor: begin
        wide = lhs_ext ^ rhs_ext;
      end
      default: begin
        wide = lhs_ext;
      end
    endcase
  end

  assign result    = wide[`CPU_DATA_W-1:0];
  assign carry_out = wide[`CPU_DATA_W]; // Zero for the logic ops.
  assign zero_out  = (result == '0);

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`CPU_STEP_W-1:0]   step,
  input  wire opcode_e                  opcode,
  input  wire reg_sel_e                 r_sel,
  input  wire logic [`CPU_IMM_W-1:0]    imm,
  input  wire logic [`CPU_DATA_W-1:0]   result,
  input  wire logic                     carry_out,
  input  wire logic                     zero_out,
  output logic      [`CPU_DATA_W-1:0]   a_val,
  output logic      [`CPU_DATA_W-1:0]   b_val,
  output logic      [`CPU_MADDR_W-1:0]  x_val,
  output logic      [`CPU_MADDR_W-1:0]  y_val,
  output logic                          carry,
  output logic                          zero
);

  logic write_back;

  assign write_back = (step == `CPU_LAST_STEP);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_val <= '0;
      b_val <= '0;
      x_val <= '0;
      y_val <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else if (write_back) begin
      // MX and MY destinations go out through the memory port.
      if (writes_r(opcode)) begin
        case (r_sel)
          sel_a:   a_val <= result;
          sel_b:   b_val <= result;
          default: ;
        endcase
      end

      case (opcode)
        op_add_ri, op_add_rq, op_sub_rq: begin
          carry <= carry_out;
          zero  <= zero_out;
        end
        op_and_rq, op_or_rq, op_xor_rq: begin
          zero <= zero_out; // Carry untouched.
        end
        op_ld_x: begin
          x_val <= `CPU_MADDR_W'(imm); // Upper nibble cleared.
        end
        op_ld_y: begin
          y_val <= `CPU_MADDR_W'(imm);
        end
        op_inc_x: begin
          x_val <= x_val + `CPU_MADDR_W'(1);
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Registers only move on the edge that ends step 3.

  a_update_in_last_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    !write_back |=> $stable({a_val, b_val, x_val, y_val, carry, zero})
  ) else $error("register changed outside the write-back step");

endmodule

`default_nettype wire

/* hdl/memory_port.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memory_port import cpu_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`CPU_STEP_W-1:0]   step,
  input  wire opcode_e                  opcode,
  input  wire reg_sel_e                 r_sel,
  input  wire reg_sel_e                 q_sel,
  input  wire logic [`CPU_MADDR_W-1:0]  x_val,
  input  wire logic [`CPU_MADDR_W-1:0]  y_val,
  input  wire logic [`CPU_DATA_W-1:0]   result,
  input  wire logic [`CPU_DATA_W-1:0]   memory_read_data,
  output logic      [`CPU_MADDR_W-1:0]  memory_addr,
  output logic                          memory_write_en,
  output logic      [`CPU_DATA_W-1:0]   memory_write_data,
  output logic      [`CPU_DATA_W-1:0]   r_mem,
  output logic      [`CPU_DATA_W-1:0]   q_mem
);

  logic [`CPU_MADDR_W-1:0] r_addr;
  logic [`CPU_MADDR_W-1:0] q_addr;
  logic                    r_in_ram;

  assign r_addr   = (r_sel == sel_my) ? y_val : x_val;
  assign q_addr   = (q_sel == sel_my) ? y_val : x_val;
  assign r_in_ram = (r_sel == sel_mx) || (r_sel == sel_my);

  // Only step 2 looks at q; r owns the bus otherwise.
  assign memory_addr = (step == `CPU_STEP_W'(2)) ? q_addr : r_addr;

  // RAM answers a cycle late, so r shows up in step 2.
  always_ff @(posedge clk) begin
    if (step == `CPU_STEP_W'(2)) begin
      r_mem <= memory_read_data;
    end
  end

  assign q_mem = memory_read_data; // Valid in step 3.

  assign memory_write_en   = (step == `CPU_LAST_STEP) && writes_r(opcode) && r_in_ram;
  assign memory_write_data = result;

  a_single_write_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    memory_write_en |=> !memory_write_en
  ) else $error("write strobe longer than one cycle");

endmodule

`default_nettype wire

/* hdl/cpu.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  output logic      [`CPU_PC_W-1:0]     rom_addr,
  input  wire logic [`CPU_INSTR_W-1:0]  rom_data,
  output logic      [`CPU_MADDR_W-1:0]  memory_addr,
  output logic                          memory_write_en,
  output logic      [`CPU_DATA_W-1:0]   memory_write_data,
  input  wire logic [`CPU_DATA_W-1:0]   memory_read_data,
  output logic                          halt
);

  logic [`CPU_STEP_W-1:0]  step;
  opcode_e                 opcode;
  reg_sel_e                r_sel;
  reg_sel_e                q_sel;
  alu_op_e                 alu_op;
  logic [`CPU_IMM_W-1:0]   imm;
  logic [`CPU_DATA_W-1:0]  a_val;
  logic [`CPU_DATA_W-1:0]  b_val;
  logic [`CPU_MADDR_W-1:0] x_val;
  logic [`CPU_MADDR_W-1:0] y_val;
  logic                    carry;
  logic                    zero;
  logic [`CPU_DATA_W-1:0]  r_mem;
  logic [`CPU_DATA_W-1:0]  q_mem;
  logic [`CPU_DATA_W-1:0]  r_val;
  logic [`CPU_DATA_W-1:0]  q_val;
  logic [`CPU_DATA_W-1:0]  lhs;
  logic [`CPU_DATA_W-1:0]  result;
  logic                    carry_out;
  logic                    zero_out;

  //////////////////////////////
  // Operand multiplexer.

  always_comb begin
    case (r_sel)
      sel_a:   r_val = a_val;
      sel_b:   r_val = b_val;
      default: r_val = r_mem;
    endcase
    case (q_sel)
      sel_a:   q_val = a_val;
      sel_b:   q_val = b_val;
      default: q_val = q_mem;
    endcase
  end

  // Short forms put the nibble immediate on the left.
  assign lhs = (opcode == op_ld_ri || opcode == op_add_ri) ? imm[`CPU_DATA_W-1:0] : r_val;

  fetch_decode u_fetch_decode (
    .clk(clk), .rst_n(rst_n), .rom_data(rom_data), .carry(carry), .zero(zero),
    .rom_addr(rom_addr), .step(step), .opcode(opcode), .r_sel(r_sel),
    .q_sel(q_sel), .alu_op(alu_op), .imm(imm), .halt(halt)
  );

  alu u_alu (
    .alu_op(alu_op), .lhs(lhs), .rhs(q_val),
    .carry_out(carry_out), .zero_out(zero_out), .result(result)
  );

  register_file u_register_file (
    .clk(clk), .rst_n(rst_n), .step(step), .opcode(opcode), .r_sel(r_sel),
    .imm(imm), .result(result), .carry_out(carry_out), .zero_out(zero_out),
    .a_val(a_val), .b_val(b_val), .x_val(x_val), .y_val(y_val),
    .carry(carry), .zero(zero)
  );

  memory_port u_memory_port (
    .clk(clk), .rst_n(rst_n), .step(step), .opcode(opcode), .r_sel(r_sel),
    .q_sel(q_sel), .x_val(x_val), .y_val(y_val), .result(result),
    .memory_read_data(memory_read_data), .memory_addr(memory_addr),
    .memory_write_en(memory_write_en), .memory_write_data(memory_write_data),
    .r_mem(r_mem), .q_mem(q_mem)
  );

endmodule

`default_nettype wire

/* test/tb_checker.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_checker (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic [`CPU_PC_W-1:0]     rom_addr,
  input  wire logic [`CPU_MADDR_W-1:0]  memory_addr,
  input  wire logic                     memory_write_en,
  input  wire logic [`CPU_DATA_W-1:0]   memory_write_data,
  input  wire logic                     halt,
  input  wire logic                     done,
  input  wire logic [127:0]             test_name,
  input  var  int                       exp_count,
  input  wire logic [4*`CPU_MADDR_W-1:0] exp_addr,
  input  wire logic [4*`CPU_DATA_W-1:0] exp_data,
  input  wire logic [`CPU_PC_W-1:0]     exp_halt_pc,
  output int                            tests_run,
  output int                            tests_failed
);

  int writes;
  int errors;

  initial begin
    tests_run    = 0;
    tests_failed = 0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      writes = 0; // Per-test counters clear while reset is held.
      errors = 0;
    end else begin
      //////////////////////////////
      // Writes, in program order.
      if (memory_write_en) begin
        if (writes >= exp_count) begin
          $display("%0s: unexpected write of %h to address %h", test_name,
                   memory_write_data, memory_addr);
          errors++;
        end else begin
          if (memory_addr !== exp_addr[writes*`CPU_MADDR_W +: `CPU_MADDR_W]) begin
            $display("CHECK FAILED %0s write %0d address: expected %h, actual %h",
                     test_name, writes,
                     exp_addr[writes*`CPU_MADDR_W +: `CPU_MADDR_W], memory_addr);
            errors++;
          end
          if (memory_write_data !== exp_data[writes*`CPU_DATA_W +: `CPU_DATA_W]) begin
            $display("CHECK FAILED %0s write %0d data: expected %h, actual %h",
                     test_name, writes,
                     exp_data[writes*`CPU_DATA_W +: `CPU_DATA_W], memory_write_data);
            errors++;
          end
        end
        writes++;
      end

      //////////////////////////////
      // End of test, some cycles after halt.
      if (done) begin
        if (writes != exp_count) begin
          $display("CHECK FAILED %0s write count: expected %0d, actual %0d",
                   test_name, exp_count, writes);
          errors++;
        end
        if (halt !== 1'b1) begin
          $display("%0s: halt dropped after it was raised", test_name);
          errors++;
        end
        if (rom_addr !== exp_halt_pc) begin
          $display("CHECK FAILED %0s halt pc: expected %h, actual %h",
                   test_name, exp_halt_pc, rom_addr);
          errors++;
        end
        tests_run++;
        if (errors != 0) begin
          tests_failed++;
          $display("FAIL %0s (%0d errors)", test_name, errors);
        end else begin
          $display("PASS %0s", test_name);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_top;

  localparam int N_TESTS    = 5;
  localparam int PERIOD_NS  = 40;
  localparam int TIMEOUT_NS = N_TESTS * (20 * `CPU_STEPS * PERIOD_NS + 8 * PERIOD_NS);

  typedef struct {
    logic [127:0]             name;
    logic [`CPU_INSTR_W-1:0]  prog [16];
    int                       n_wr;
    logic [`CPU_MADDR_W-1:0]  wr_addr [4];
    logic [`CPU_DATA_W-1:0]   wr_data [4];
    int                       sum_slot; // Write whose data is ram[sum_a] + ram[sum_b].
    logic [`CPU_MADDR_W-1:0]  sum_a;
    logic [`CPU_MADDR_W-1:0]  sum_b;
    logic [`CPU_PC_W-1:0]     halt_pc;
  } test_t;

  test_t tests [N_TESTS];

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic [`CPU_PC_W-1:0]      rom_addr;
  logic [`CPU_INSTR_W-1:0]   rom_data = '0;
  logic [`CPU_MADDR_W-1:0]   memory_addr;
  logic                      memory_write_en;
  logic [`CPU_DATA_W-1:0]    memory_write_data;
  logic [`CPU_DATA_W-1:0]    memory_read_data = '0;
  logic                      halt;
  logic                      done;
  logic [127:0]              test_name;
  int                        exp_count;
  logic [4*`CPU_MADDR_W-1:0] exp_addr;
  logic [4*`CPU_DATA_W-1:0]  exp_data;
  logic [`CPU_PC_W-1:0]      exp_halt_pc;
  int                        tests_run;
  int                        tests_failed;

  logic [`CPU_INSTR_W-1:0]   rom [1 << `CPU_PC_W];
  logic [`CPU_DATA_W-1:0]    ram [1 << `CPU_MADDR_W];

  always #(PERIOD_NS / 2) clk = ~clk;

  // Synchronous ROM and RAM, one clock of read latency.
  always @(posedge clk) begin
    rom_data <= rom[rom_addr];
    memory_read_data <= ram[memory_addr];
    if (memory_write_en) begin
      ram[memory_addr] = memory_write_data;
    end
  end

  cpu dut0 (
    .clk(clk), .rst_n(rst_n), .rom_addr(rom_addr), .rom_data(rom_data),
    .memory_addr(memory_addr), .memory_write_en(memory_write_en),
    .memory_write_data(memory_write_data), .memory_read_data(memory_read_data),
    .halt(halt)
  );

  tb_checker checker0 (
    .clk(clk), .rst_n(rst_n), .rom_addr(rom_addr), .memory_addr(memory_addr),
    .memory_write_en(memory_write_en), .memory_write_data(memory_write_data),
    .halt(halt), .done(done), .test_name(test_name), .exp_count(exp_count),
    .exp_addr(exp_addr), .exp_data(exp_data), .exp_halt_pc(exp_halt_pc),
    .tests_run(tests_run), .tests_failed(tests_failed)
  );

  //////////////////////////////
  // Watchdog.

  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("Timeout: the core did not halt within %0d ns", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////
  // Test table.

  initial begin
    tests[0].name    = "load_store";
    tests[0].prog    = '{12'h710, 12'h820, 12'h005, 12'h01C, 12'h023, 12'h030, 12'h20D, 12'h208,
                         12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00};
    tests[0].n_wr    = 4;
    tests[0].wr_addr = '{12'h010, 12'h020, 12'h020, 12'h010};
    tests[0].wr_data = '{4'h3, 4'h0, 4'hC, 4'h8};
    tests[0].halt_pc = 13'd8;

    // 9 + 8 carries, so jp_c skips the marker at 4; 1 - 2 borrows past jp_nc.
    tests[1].name    = "carry_borrow";
    tests[1].prog    = '{12'h730, 12'h009, 12'h108, 12'hB06, 12'h02E, 12'hF00, 12'h020, 12'h208,
                         12'h012, 12'h301, 12'hC0E, 12'h027, 12'hF00, 12'hF00, 12'h025, 12'hF00};
    tests[1].n_wr    = 3;
    tests[1].wr_addr = '{12'h030, 12'h030, 12'h030, 12'h000};
    tests[1].wr_data = '{4'h0, 4'h1, 4'h7, 4'h0};
    tests[1].halt_pc = 13'd12;

    tests[2].name    = "logic_zero";
    tests[2].prog    = '{12'h740, 12'h006, 12'h016, 12'h601, 12'hD07, 12'h02F, 12'hF00, 12'h02C,
                         12'h409, 12'h509, 12'h609, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00};
    tests[2].n_wr    = 4;
    tests[2].wr_addr = '{12'h040, 12'h040, 12'h040, 12'h040};
    tests[2].wr_data = '{4'hC, 4'h4, 4'h6, 4'h0}; // C&6, 4|6, 6^6.
    tests[2].halt_pc = 13'd11;

    tests[3].name    = "indexing";
    tests[3].prog    = '{12'h750, 12'h860, 12'h000, 12'h202, 12'h203, 12'h900, 12'h020, 12'h208,
                         12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00};
    tests[3].n_wr    = 2;
    tests[3].wr_addr = '{12'h051, 12'h051, 12'h000, 12'h000};
    tests[3].wr_data = '{4'h0, 4'h0, 4'h0, 4'h0};
    tests[3].halt_pc = 13'd8;

    tests[4].name    = "halt_stop";
    tests[4].prog    = '{12'h770, 12'h029, 12'hF00, 12'h021, 12'h021, 12'hF00, 12'hF00, 12'hF00,
                         12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00, 12'hF00};
    tests[4].n_wr    = 1;
    tests[4].wr_addr = '{12'h070, 12'h000, 12'h000, 12'h000};
    tests[4].wr_data = '{4'h9, 4'h0, 4'h0, 4'h0};
    tests[4].halt_pc = 13'd2;

    for (int t = 0; t < N_TESTS; t++) begin
      tests[t].sum_slot = (t == 3) ? 1 : -1;
      tests[t].sum_a    = 12'h050;
      tests[t].sum_b    = 12'h060;
    end
  end

  //////////////////////////////
  // Sequencing loop.

  initial begin
    rst_n     = 1'b0;
    done      = 1'b0;
    test_name = '0;
    exp_count = 0;
    exp_addr  = '0;
    exp_data  = '0;
    exp_halt_pc = '0;
    void'($urandom(39819));
    for (int a = 0; a < (1 << `CPU_PC_W); a++) begin
      rom[a] = 12'hF00;
    end

    for (int t = 0; t < N_TESTS; t++) begin
      @(negedge clk);
      rst_n = 1'b0;
      for (int j = 0; j < 16; j++) begin
        rom[j] = tests[t].prog[j];
      end
      for (int a = 0; a < (1 << `CPU_MADDR_W); a++) begin
        ram[a] = 4'($urandom);
      end
      test_name   = tests[t].name;
      exp_count   = tests[t].n_wr;
      exp_halt_pc = tests[t].halt_pc;
      for (int k = 0; k < 4; k++) begin
        exp_addr[k*`CPU_MADDR_W +: `CPU_MADDR_W] = tests[t].wr_addr[k];
        if (k == tests[t].sum_slot) begin
          exp_data[k*`CPU_DATA_W +: `CPU_DATA_W] = ram[tests[t].sum_a] + ram[tests[t].sum_b];
        end else begin
          exp_data[k*`CPU_DATA_W +: `CPU_DATA_W] = tests[t].wr_data[k];
        end
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      while (halt !== 1'b1) @(negedge clk);
      repeat (8) @(negedge clk); // Room for any stray write after halt.
      done = 1'b1;
      @(negedge clk);
      done = 1'b0;
    end

    @(negedge clk);
    $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
    if (tests_failed == 0 && tests_run == N_TESTS) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_decode.sv
hdl/alu.sv
hdl/register_file.sv
hdl/memory_port.sv
hdl/cpu.sv
test/tb_checker.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1
